// ==== dbusPath.f ====
ks10CromPkg.sv
ks10BusPkg.sv
ramFile.sv
dbmMux.sv
dbusMux.sv
dbusPath.sv
dbusChecker.sv
tbDbusPath.sv

// ==== Makefile ====
# Verilator build and run, lint and clean for the DBUS path

VERILATOR ?= verilator
TOP       ?= tbDbusPath
RTL_TOP   ?= dbusPath
FILELIST  ?= dbusPath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

TB_SRCS  := tbDbusPath.sv dbusChecker.sv
RTL_SRCS := $(filter-out $(TB_SRCS),$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tbDbusPath.sv ====
// Testbench top with clock, reset, LFSR stimulus, DUT, checker and timeout

`timescale 1ns/1ps

module tbDbusPath
   import ks10CromPkg::*;
   import ks10BusPkg::*;
();

   ////////////////////
   // Run lengths
   ////////////////////

   localparam int resetCycles = 10;
   localparam int testCount   = 6;
   localparam int shortLen    = 500;
   localparam int longLen     = 1000;
   localparam int runLen      = resetCycles + (testCount - 1) * shortLen + longLen;
   // Ten percent margin over reset plus all tests
   localparam int cycleLimit  = runLen + runLen / 10;

   logic                    clk = 1'b0;
   logic                    rst;
   cromWord                 crom;
   ks10Word                 dp;
   ks10Word                 memData;
   vmaWord                  vma;
   logic [0:17]             pcFlags;
   logic [0:2]              reqIntp;
   logic                    cacheHit;
   logic [ramAddrWidth-1:0] ramAddr;
   dbusWord                 dbus;

   logic [31:0] lfsr = 32'hfa0e_5e2f;
   int          testId;
   int          cycleCount = 0;
   int          checkTotal;
   int          errTotal;

   // 100 ns period
   always #50 clk = ~clk;

   dbusPath u_dut
   (
      .clk      (clk),
      .rst      (rst),
      .crom     (crom),
      .dp       (dp),
      .memData  (memData),
      .vma      (vma),
      .pcFlags  (pcFlags),
      .reqIntp  (reqIntp),
      .cacheHit (cacheHit),
      .ramAddr  (ramAddr),
      .dbus     (dbus)
   );

   dbusChecker u_checker
   (
      .clk        (clk),
      .rst        (rst),
      .crom       (crom),
      .dp         (dp),
      .memData    (memData),
      .vma        (vma),
      .pcFlags    (pcFlags),
      .reqIntp    (reqIntp),
      .cacheHit   (cacheHit),
      .ramAddr    (ramAddr),
      .dbus       (dbus),
      .testId     (testId),
      .checkTotal (checkTotal),
      .errTotal   (errTotal)
   );

   ////////////////////
   // Random source
   ////////////////////

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      lfsrStep = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   task automatic takeBits(input int n, output logic [35:0] val);
      int i;
      val = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr = lfsrStep(lfsr);
         val  = {val[34:0], lfsr[0]};
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   // Random word set, then shaped per test
   task automatic driveCycle(input int id);
      logic [35:0] r;
      cromWord     c;
      vmaWord      v;
      takeBits(36, r);
      c = r;
      takeBits(36, r);
      dp = r;
      takeBits(36, r);
      memData = r;
      takeBits(36, r);
      v = r;
      takeBits(18, r);
      pcFlags = r[17:0];
      takeBits(3, r);
      reqIntp = r[2:0];
      takeBits(1, r);
      cacheHit = r[0];
      takeBits(ramAddrWidth, r);
      ramAddr = r[ramAddrWidth-1:0];
      case (id)
         1:
         begin
            // Flags output while every address gets written
            c.dbusSel  = dbusSelFlags;
            c.ramWrite = 1'b1;
         end
         2:
         begin
            c.dbusSel = dbusSelFlags;
         end
         3:
         begin
            // Eight addresses so reads hit recent writes
            takeBits(1, r);
            c.dbusSel    = r[0] ? dbusSelRamfile : dbusSelDp;
            ramAddr[5:3] = 3'b0;
         end
         4:
         begin
            // No read cycle so DBM is never replaced
            c.dbusSel            = dbusSelDbm;
            v.flags.readCycle    = 1'b0;
         end
         5:
         begin
            c.dbusSel         = dbusSelDbm;
            v.flags.readCycle = 1'b1;
            cacheHit          = 1'b0;
            takeBits(2, r);
            if (r[0])
            begin
               v.addr[18:31] = '0;
            end
            if (r[1])
            begin
               c.jAddr = acExcludeAddr;
            end
         end
         default:
         begin
            // Fully random, exclusion address one time in four
            takeBits(2, r);
            if (r[1:0] == 2'b00)
            begin
               c.jAddr = acExcludeAddr;
            end
         end
      endcase
      crom = c;
      vma  = v;
   endtask

   ////////////////////
   // Sequence
   ////////////////////

   initial
   begin
      rst      = 1'b1;
      crom     = '0;
      dp       = '0;
      memData  = '0;
      vma      = '0;
      pcFlags  = '0;
      reqIntp  = '0;
      cacheHit = 1'b0;
      ramAddr  = '0;
      testId   = 1;
      repeat (resetCycles) @(posedge clk);
      #5;
      rst = 1'b0;
      for (int id = 1; id <= testCount; id++)
      begin
         testId = id;
         repeat ((id == testCount) ? longLen : shortLen)
         begin
            driveCycle(id);
            @(posedge clk);
            #5;
         end
      end
      // Idle id flushes the last test line out of the checker
      testId = 0;
      repeat (3) @(posedge clk);
      $display("Total checks %0d, errors %0d", checkTotal, errTotal);
      if (errTotal == 0 && checkTotal > 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         if (checkTotal == 0)
         begin
            $display("No output was ever compared");
         end
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Run limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
         $display("Timeout: run not finished after %0d cycles", cycleLimit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

endmodule

// ==== dbusChecker.sv ====
// Testbench model of ramfile, DBM and DBUS with per-cycle compare and per-test lines

`timescale 1ns/1ps

module dbusChecker
   import ks10BusPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  ks10Word                 crom,
   input  ks10Word                 dp,
   input  ks10Word                 memData,
   input  ks10Word                 vma,
   input  logic [0:17]             pcFlags,
   input  logic [0:2]              reqIntp,
   input  logic                    cacheHit,
   input  logic [ramAddrWidth-1:0] ramAddr,
   input  ks10Word                 dbus,
   input  int                      testId,
   output int                      checkTotal,
   output int                      errTotal
);

   ////////////////////
   // Model state
   ////////////////////

   ks10Word modelMem [0:63];
   logic    modelValid [0:63] = '{default: 1'b0};
   ks10Word expWord;
   logic    expKnown   = 1'b0;
   int      expTest    = 0;
   int      curTest    = 0;
   int      testChecks = 0;
   int      testSkips  = 0;
   int      testErrs   = 0;
   int      checkCount = 0;
   int      errCount   = 0;

   assign checkTotal = checkCount;
   assign errTotal   = errCount;

   function automatic string testName(int id);
      case (id)
         1:       testName = "reset";
         2:       testName = "flagsWord";
         3:       testName = "dpRamfile";
         4:       testName = "dbmSources";
         5:       testName = "acForce";
         6:       testName = "cacheHit";
         default: testName = "idle";
      endcase
   endfunction

   // pcFlags, zero, intp, four ones, VMA 26..35
   function automatic ks10Word flagsWord(logic [0:17] pcf, logic [0:2] intp, ks10Word v);
      flagsWord = {pcf, 1'b0, intp, 4'b1111, v[26:35]};
   endfunction

   // Microword bits 14..15 pick the DBM source
   function automatic ks10Word dbmWord(ks10Word c, ks10Word d, ks10Word m, ks10Word v);
      case (c[14:15])
         2'd0:    dbmWord = m;
         2'd1:    dbmWord = v;
         2'd2:    dbmWord = {c[18:35], c[18:35]};
         default: dbmWord = {d[18:35], d[0:17]};
      endcase
   endfunction

   // VMA bit 3 read cycle, bit 8 physical
   function automatic logic ramForced(ks10Word c, ks10Word v, logic hit);
      logic acRef;
      acRef     = (v[8] == 1'b0) && (v[18:31] == '0);
      ramForced = v[3] && (hit || (acRef && (c[0:11] != 12'o1146)));
   endfunction

   ////////////////////
   // Predict at the edge
   ////////////////////

   always @(posedge clk)
   begin
      expTest  = testId;
      if (rst)
      begin
         // Cleared controls give the flags word of all zero sources
         expWord  = flagsWord('0, '0, '0);
         expKnown = 1'b1;
      end
      else
      begin
         expKnown = 1'b1;
         case (crom[12:13])
            2'd0:    expWord = flagsWord(pcFlags, reqIntp, vma);
            2'd1:    expWord = dp;
            2'd2:
            begin
               expWord  = modelMem[ramAddr];
               expKnown = modelValid[ramAddr];
            end
            default:
            begin
               if (ramForced(crom, vma, cacheHit))
               begin
                  expWord  = modelMem[ramAddr];
                  expKnown = modelValid[ramAddr];
               end
               else
               begin
                  expWord = dbmWord(crom, dp, memData, vma);
               end
            end
         endcase
         // Write after the read so a same-edge read sees the old word
         if (crom[16])
         begin
            modelMem[ramAddr]   = dp;
            modelValid[ramAddr] = 1'b1;
         end
      end
   end

   ////////////////////
   // Compare mid-cycle
   ////////////////////

   task reportTest();
      $display("test %0d %s: %0d checks, %0d skipped, %0d errors%s", curTest,
               testName(curTest), testChecks, testSkips, testErrs,
               (testErrs == 0) ? "" : " (FAILED)");
   endtask

   always @(negedge clk)
   begin
      if (expTest != curTest)
      begin
         if (curTest != 0)
         begin
            reportTest();
         end
         curTest    = expTest;
         testChecks = 0;
         testSkips  = 0;
         testErrs   = 0;
      end
      if (curTest != 0)
      begin
         // Nothing to compare for an unwritten model word
         if (!expKnown)
         begin
            testSkips++;
         end
         else
         begin
            testChecks++;
            checkCount++;
            if (dbus !== expWord)
            begin
               testErrs++;
               errCount++;
               $display("ERR %s: expected %012o actual %012o", testName(curTest),
                        expWord, dbus);
            end
         end
      end
   end

endmodule

// ==== dbusPath.sv ====
// DBUS data path top with ramfile, DBM stage and DBUS selector

`timescale 1ns/1ps

module dbusPath
   import ks10CromPkg::*;
   import ks10BusPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  cromWord                 crom,
   input  ks10Word                 dp,
   input  ks10Word                 memData,
   input  vmaWord                  vma,
   input  logic [0:17]             pcFlags,
   input  logic [0:2]              reqIntp,
   input  logic                    cacheHit,
   input  logic [ramAddrWidth-1:0] ramAddr,
   output dbusWord                 dbus
);

   ////////////////////
   // Stage outputs
   ////////////////////

   // Both valid one edge after sampling
   ks10Word ramData;
   ks10Word dbm;

   // AC and cache storage, written from the datapath
   ramFile u_ramFile
   (
      .clk    (clk),
      .rst    (rst),
      .addr   (ramAddr),
      .write  (crom.ramWrite),
      .wrData (dp),
      .rdData (ramData)
   );

   // Data bus mux stage
   dbmMux u_dbmMux
   (
      .clk     (clk),
      .rst     (rst),
      .sel     (crom.dbmSel),
      .number  (crom.number),
      .memData (memData),
      .vma     (vma),
      .dp      (dp),
      .dbm     (dbm)
   );

   // Final DBUS source and ramfile forcing
   dbusMux u_dbusMux
   (
      .clk      (clk),
      .rst      (rst),
      .crom     (crom),
      .vma      (vma),
      .cacheHit (cacheHit),
      .dp       (dp),
      .pcFlags  (pcFlags),
      .reqIntp  (reqIntp),
      .ramData  (ramData),
      .dbm      (dbm),
      .dbus     (dbus)
   );

endmodule

// ==== dbusMux.sv ====
// DBUS control register, AC-reference and force-ramfile decode, DBUS select

`timescale 1ns/1ps

module dbusMux
   import ks10CromPkg::*;
   import ks10BusPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  cromWord     crom,
   input  vmaWord      vma,
   input  logic        cacheHit,
   input  ks10Word     dp,
   input  logic [0:17] pcFlags,
   input  logic [0:2]  reqIntp,
   input  ks10Word     ramData,
   input  ks10Word     dbm,
   output dbusWord     dbus
);

   ////////////////////
   // Input decode
   ////////////////////

   logic   acRef;
   logic   forceRamfile;
   dbusCtl ctlNext;
   dbusCtl ctl;

   // AC reference
   // Virtual access to the lowest 16 words, never physical
   assign acRef = ~vma.flags.physical & (vma.addr[18:31] == 14'b0);

   // Ramfile replaces DBM on a read of an AC or a cached word
   // AC case is skipped at microcode address 1146
   assign forceRamfile = vma.flags.readCycle &
                         ((acRef & (crom.jAddr != acExcludeAddr)) | cacheHit);

   always_comb
   begin
      ctlNext.dbusSel      = crom.dbusSel;
      ctlNext.forceRamfile = forceRamfile;
      ctlNext.dp           = dp;
      ctlNext.pcFlags      = pcFlags;
      ctlNext.reqIntp      = reqIntp;
      // Only the low VMA bits show in the flags word
      ctlNext.vmaLow       = vma.addr[26:35];
   end

   ////////////////////
   // Control register
   ////////////////////

   // Same edge as ramfile read and DBM register
   // Cleared state selects the flags word
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctl <= '0;
      end
      else
      begin
         ctl <= ctlNext;
      end
   end

   ////////////////////
   // DBUS select
   ////////////////////

   always_comb
   begin
      case (ctl.dbusSel)
         dbusSelFlags:
         begin
            // Processor flags word
            dbus.flags.pcFlags = ctl.pcFlags;
            dbus.flags.zero    = 1'b0;
            dbus.flags.reqIntp = ctl.reqIntp;
            dbus.flags.ones    = 4'b1111;
            dbus.flags.vmaLow  = ctl.vmaLow;
         end
         dbusSelDp:
         begin
            dbus.raw = ctl.dp;
         end
         dbusSelRamfile:
         begin
            dbus.raw = ramData;
         end
         default:
         begin
            // DBM unless the ramfile is forced
            dbus.raw = ctl.forceRamfile ? ramData : dbm;
         end
      endcase
   end

endmodule

// ==== dbmMux.sv ====
// Registered four-way data bus mux over memory, VMA, number field and swapped datapath

`timescale 1ns/1ps

module dbmMux
   import ks10CromPkg::*;
   import ks10BusPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic [0:1]  sel,
   input  logic [0:17] number,
   input  ks10Word     memData,
   input  vmaWord      vma,
   input  ks10Word     dp,
   output ks10Word     dbm
);

   ////////////////////
   // Source select
   ////////////////////

   ks10Word dbmNext;

   always_comb
   begin
      case (sel)
         dbmSelMem:
         begin
            // Main memory data
            dbmNext = memData;
         end
         dbmSelVma:
         begin
            // VMA flags then address
            dbmNext = vma;
         end
         dbmSelNum:
         begin
            // Number field in both halves
            dbmNext = {number, number};
         end
         default:
         begin
            // Left and right halves exchanged
            dbmNext = {dp[18:35], dp[0:17]};
         end
      endcase
   end

   ////////////////////
   // Output register
   ////////////////////

   // Lines up with the ramfile read
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         dbm <= '0;
      end
      else
      begin
         dbm <= dbmNext;
      end
   end

endmodule

// ==== ramFile.sv ====
// Synchronous 64-word AC and cache ramfile with registered read

`timescale 1ns/1ps

module ramFile
   import ks10BusPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic [ramAddrWidth-1:0] addr,
   input  logic                    write,
   input  ks10Word                 wrData,
   output ks10Word                 rdData
);

   ////////////////////
   // Storage
   ////////////////////

   // ACs live in the low words
   ks10Word mem [0:ramDepth-1];

   // Write strobe qualified by reset
   logic writeEn;

   assign writeEn = write & ~rst;

   ////////////////////
   // Write port
   ////////////////////

   // Datapath word stored at the sampled address
   always_ff @(posedge clk)
   begin
      if (writeEn)
      begin
         mem[addr] <= wrData;
      end
   end

   ////////////////////
   // Read port
   ////////////////////

   // One cycle read
   // Same-edge write is not visible, old word comes back
   always_ff @(posedge clk)
   begin
      rdData <= mem[addr];
   end

endmodule

// ==== ks10BusPkg.sv ====
// Data word, VMA, flags word, DBUS view and DBUS control types, ramfile size

package ks10BusPkg;

   ////////////////////
   // Basic words
   ////////////////////

   // 36-bit machine word, bit 0 is the MSB
   typedef logic [0:35] ks10Word;

   // Ramfile holds ACs and cache words
   localparam int ramAddrWidth = 6;
   localparam int ramDepth     = 1 << ramAddrWidth;

   ////////////////////
   // VMA
   ////////////////////

   // Only read cycle and physical are decoded here
   typedef struct packed
   {
      logic [0:2]  flags0to2;
      logic        readCycle;
      logic [4:7]  flags4to7;
      logic        physical;
      logic [9:13] flags9to13;
   } vmaFlags;

   // Flags in the left bits, address in bits 14 to 35
   typedef struct packed
   {
      vmaFlags      flags;
      logic [14:35] addr;
   } vmaWord;

   ////////////////////
   // DBUS
   ////////////////////

   // Processor flags layout of the DBUS word
   typedef struct packed
   {
      logic [0:17]  pcFlags;
      logic         zero;
      logic [0:2]   reqIntp;
      logic [0:3]   ones;
      logic [26:35] vmaLow;
   } flagsView;

   // Same 36 bits seen raw or as flags
   typedef union packed
   {
      ks10Word  raw;
      flagsView flags;
   } dbusWord;

   // Registered DBUS controls and flags-word sources
   typedef struct packed
   {
      logic [0:1]   dbusSel;
      logic         forceRamfile;
      ks10Word      dp;
      logic [0:17]  pcFlags;
      logic [0:2]   reqIntp;
      logic [26:35] vmaLow;
   } dbusCtl;

endpackage

// ==== ks10CromPkg.sv ====
// Microword layout, DBUS and DBM select codes, AC exclusion address

package ks10CromPkg;

   ////////////////////
   // Microword
   ////////////////////

   // Width of one control ROM word
   localparam int cromWidth = 36;

   // Fields listed from bit 0 (most significant) down
   // Number field keeps its microword bit positions 18 to 35
   typedef struct packed
   {
      logic [0:11]                  jAddr;
      logic [0:1]                   dbusSel;
      logic [0:1]                   dbmSel;
      logic                         ramWrite;
      logic                         spare;
      logic [cromWidth-18:cromWidth-1] number;
   } cromWord;

   ////////////////////
   // Select codes
   ////////////////////

   // DBUS source
   localparam logic [0:1] dbusSelFlags   = 2'd0;
   localparam logic [0:1] dbusSelDp      = 2'd1;
   localparam logic [0:1] dbusSelRamfile = 2'd2;
   localparam logic [0:1] dbusSelDbm     = 2'd3;

   // DBM source
   localparam logic [0:1] dbmSelMem    = 2'd0;
   localparam logic [0:1] dbmSelVma    = 2'd1;
   localparam logic [0:1] dbmSelNum    = 2'd2;
   localparam logic [0:1] dbmSelDpSwap = 2'd3;

   // Microcode location that never forces the ramfile on an AC reference
   localparam logic [0:11] acExcludeAddr = 12'o1146;

endpackage
